//--- rtl/axis2axi_rd_pkg.sv
/*
 * AXI read to AXI-Stream DMA, shared widths and planner state encoding
 */

package axis2axi_rd_pkg;

   // AXI address width, one word per address step of DATA_W/8 bytes
   localparam int ADDR_W = 32;

   // Data word width
   localparam int DATA_W = 32;

   // Burst length field, max burst is 2**LEN_W beats
   localparam int LEN_W = 4;

   // FIFO depth of 2**FIFO_AW, at least one max burst
   localparam int FIFO_AW = 5;

   // Transfer length in words
   localparam int RLEN_W = 12;

   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      ISSUE    = 2'd1,
      WAIT_ACK = 2'd2
   } plan_state_e;

endpackage

//--- rtl/burst_req_if.sv
/*
 * Burst request link between planner and burst engine, four-phase req/ack
 */

`timescale 1ns/1ns

interface burst_req_if #(
   parameter int ADDR_W = axis2axi_rd_pkg::ADDR_W,
   parameter int LEN_W  = axis2axi_rd_pkg::LEN_W
);

   logic              req;
   logic              ack;
   logic [ADDR_W-1:0] addr;
   // Beats in burst, 1 to 2**LEN_W
   logic [LEN_W:0]    len;

   modport planner (output req, output addr, output len, input ack);

   modport engine (input req, input addr, input len, output ack);

endinterface

//--- rtl/rd_burst_planner.sv
/*
 * Read burst planner, splits a transfer into bursts that fit the max burst
 * length and the free FIFO space, one burst open at a time
 */

`timescale 1ns/1ns

module rd_burst_planner #(
   parameter int ADDR_W  = axis2axi_rd_pkg::ADDR_W,
   parameter int DATA_W  = axis2axi_rd_pkg::DATA_W,
   parameter int LEN_W   = axis2axi_rd_pkg::LEN_W,
   parameter int FIFO_AW = axis2axi_rd_pkg::FIFO_AW,
   parameter int RLEN_W  = axis2axi_rd_pkg::RLEN_W
) (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic                 start_i,
   input  logic [ADDR_W-1:0]    addr_i,
   input  logic [RLEN_W-1:0]    length_i,
   input  logic [LEN_W:0]       max_len_i,
   input  logic [FIFO_AW:0]     fifo_level_i,
   output logic                 busy_o,
   burst_req_if.planner         breq
);

   localparam int DEPTH = 1 << FIFO_AW;
   localparam int BYTES = DATA_W / 8;
   // Common width for the length comparisons
   localparam int CW    = 32;

   axis2axi_rd_pkg::plan_state_e state_q;

   logic [RLEN_W-1:0] remaining_q;
   logic [ADDR_W-1:0] next_addr_q;
   logic              req_q;
   logic [ADDR_W-1:0] addr_q;
   logic [LEN_W:0]    len_q;

   logic [CW-1:0]     rem_w;
   logic [CW-1:0]     max_w;
   logic [CW-1:0]     free_w;
   logic [LEN_W:0]    burst_len;
   logic              accept;
   logic              idle_link;
   logic              issue;

   assign accept    = (state_q == axis2axi_rd_pkg::IDLE) && start_i;
   assign idle_link = (state_q == axis2axi_rd_pkg::ISSUE) && !req_q && !breq.ack;
   assign issue     = idle_link && (remaining_q != '0) && (burst_len != '0);

   // Burst sizing, zero means wait for space
   always_comb begin
      rem_w     = CW'(remaining_q);
      max_w     = CW'(max_len_i);
      free_w    = CW'(DEPTH) - CW'(fifo_level_i);
      burst_len = '0;
      if ((rem_w <= max_w) && (rem_w <= free_w)) begin
         burst_len = (LEN_W+1)'(remaining_q);
      end else if (free_w >= max_w) begin
         burst_len = max_len_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q     <= axis2axi_rd_pkg::IDLE;
         remaining_q <= '0;
         req_q       <= 1'b0;
      end else begin
         case (state_q)
            axis2axi_rd_pkg::IDLE: begin
               if (start_i) begin
                  remaining_q <= length_i;
                  state_q     <= axis2axi_rd_pkg::ISSUE;
               end
            end
            axis2axi_rd_pkg::ISSUE: begin
               if (idle_link && (remaining_q == '0)) begin
                  state_q <= axis2axi_rd_pkg::IDLE;
               end else if (issue) begin
                  req_q       <= 1'b1;
                  remaining_q <= remaining_q - RLEN_W'(burst_len);
                  state_q     <= axis2axi_rd_pkg::WAIT_ACK;
               end
            end
            axis2axi_rd_pkg::WAIT_ACK: begin
               // Engine acks once the last beat is in the FIFO
               if (breq.ack) begin
                  req_q   <= 1'b0;
                  state_q <= axis2axi_rd_pkg::ISSUE;
               end
            end
            default: state_q <= axis2axi_rd_pkg::IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         next_addr_q <= addr_i;
      end else if (issue) begin
         addr_q      <= next_addr_q;
         len_q       <= burst_len;
         next_addr_q <= next_addr_q + ADDR_W'(burst_len) * ADDR_W'(BYTES);
      end
   end

   assign breq.req  = req_q;
   assign breq.addr = addr_q;
   assign breq.len  = len_q;

   assign busy_o = (state_q != axis2axi_rd_pkg::IDLE);

endmodule

//--- rtl/axi_rd_burst.sv
/*
 * AXI read burst engine, one AR burst per request, R beats go into the FIFO
 */

`timescale 1ns/1ns

module axi_rd_burst #(
   parameter int ADDR_W = axis2axi_rd_pkg::ADDR_W,
   parameter int DATA_W = axis2axi_rd_pkg::DATA_W,
   parameter int LEN_W  = axis2axi_rd_pkg::LEN_W
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   burst_req_if.engine       breq,
   // AXI read address channel
   output logic [ADDR_W-1:0] araddr_o,
   output logic [LEN_W-1:0]  arlen_o,
   output logic              arvalid_o,
   input  logic              arready_i,
   // AXI read data channel
   input  logic [DATA_W-1:0] rdata_i,
   input  logic              rvalid_i,
   input  logic              rlast_i,
   output logic              rready_o,
   // FIFO write port
   output logic [DATA_W-1:0] fifo_wdata_o,
   output logic              fifo_wen_o,
   input  logic              fifo_full_i
);

   logic ar_q;
   logic rd_q;
   logic ack_q;
   logic launch;
   logic beat;

   // New request only once the previous handshake has fully closed
   assign launch = breq.req && !ack_q && !rd_q;

   assign rready_o = rd_q && !fifo_full_i;
   assign beat     = rvalid_i && rready_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ar_q  <= 1'b0;
         rd_q  <= 1'b0;
         ack_q <= 1'b0;
      end else begin
         if (launch) begin
            ar_q <= 1'b1;
         end else if (arready_i) begin
            ar_q <= 1'b0;
         end

         if (launch) begin
            rd_q <= 1'b1;
         end else if (beat && rlast_i) begin
            rd_q <= 1'b0;
         end

         // Ack after the last write, drop it once req is low
         if (rd_q && beat && rlast_i) begin
            ack_q <= 1'b1;
         end else if (!breq.req) begin
            ack_q <= 1'b0;
         end
      end
   end

   // Address and length held by the planner while req is high
   assign araddr_o  = breq.addr;
   assign arlen_o   = LEN_W'(breq.len - 1'b1);
   assign arvalid_o = ar_q;

   assign fifo_wdata_o = rdata_i;
   assign fifo_wen_o   = beat;

   assign breq.ack = ack_q;

endmodule

//--- rtl/rd_fifo.sv
/*
 * Synchronous FIFO with registered read data and a fill level output
 */

`timescale 1ns/1ns

module rd_fifo #(
   parameter int DATA_W  = axis2axi_rd_pkg::DATA_W,
   parameter int FIFO_AW = axis2axi_rd_pkg::FIFO_AW
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   // Write port
   input  logic              wen_i,
   input  logic [DATA_W-1:0] wdata_i,
   output logic              full_o,
   // Read port, data one cycle after ren
   input  logic              ren_i,
   output logic [DATA_W-1:0] rdata_o,
   output logic              empty_o,
   output logic [FIFO_AW:0]  level_o
);

   localparam int DEPTH = 1 << FIFO_AW;

   logic [DATA_W-1:0] mem [DEPTH];

   // Pointers carry a wrap bit above the index
   logic [FIFO_AW:0]  wptr_q;
   logic [FIFO_AW:0]  rptr_q;
   logic [DATA_W-1:0] rdata_q;
   logic              do_wr;
   logic              do_rd;

   assign full_o  = (wptr_q[FIFO_AW] != rptr_q[FIFO_AW]) &&
                    (wptr_q[FIFO_AW-1:0] == rptr_q[FIFO_AW-1:0]);
   assign empty_o = (wptr_q == rptr_q);
   assign level_o = wptr_q - rptr_q;

   assign do_wr = wen_i && !full_o;
   assign do_rd = ren_i && !empty_o;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wptr_q <= '0;
         rptr_q <= '0;
      end else begin
         if (do_wr) begin
            wptr_q <= wptr_q + 1'b1;
         end
         if (do_rd) begin
            rptr_q <= rptr_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wptr_q[FIFO_AW-1:0]] <= wdata_i;
      end
      if (do_rd) begin
         rdata_q <= mem[rptr_q[FIFO_AW-1:0]];
      end
   end

   assign rdata_o = rdata_q;

endmodule

//--- rtl/fifo2axis.sv
/*
 * FIFO to AXI-Stream output stage with a registered tdata/tvalid
 */

`timescale 1ns/1ns

module fifo2axis #(
   parameter int DATA_W = axis2axi_rd_pkg::DATA_W
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              fifo_empty_i,
   input  logic [DATA_W-1:0] fifo_rdata_i,
   output logic              fifo_ren_o,
   output logic [DATA_W-1:0] tdata_o,
   output logic              tvalid_o,
   input  logic              tready_i
);

   logic              pend_q;
   logic              tvalid_q;
   logic [DATA_W-1:0] tdata_q;
   logic              load;
   logic              pop;

   // Popped word waits on the FIFO read register until the output is free
   assign load = pend_q && (!tvalid_q || tready_i);
   assign pop  = !fifo_empty_i && (!pend_q || load);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         pend_q   <= 1'b0;
         tvalid_q <= 1'b0;
      end else begin
         pend_q   <= pop || (pend_q && !load);
         tvalid_q <= load || (tvalid_q && !tready_i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         tdata_q <= fifo_rdata_i;
      end
   end

   assign fifo_ren_o = pop;
   assign tdata_o    = tdata_q;
   assign tvalid_o   = tvalid_q;

endmodule

//--- rtl/axis2axi_rd.sv
/*
 * Read DMA top, moves a block of words from AXI memory to an AXI-Stream output
 */

`timescale 1ns/1ns

module axis2axi_rd #(
   parameter int ADDR_W  = axis2axi_rd_pkg::ADDR_W,
   parameter int DATA_W  = axis2axi_rd_pkg::DATA_W,
   parameter int LEN_W   = axis2axi_rd_pkg::LEN_W,
   parameter int FIFO_AW = axis2axi_rd_pkg::FIFO_AW,
   parameter int RLEN_W  = axis2axi_rd_pkg::RLEN_W
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   // Transfer control
   input  logic              start_i,
   input  logic [ADDR_W-1:0] addr_i,
   input  logic [RLEN_W-1:0] length_i,
   input  logic [LEN_W:0]    max_len_i,
   output logic              busy_o,
   // AXI read master
   output logic [ADDR_W-1:0] araddr_o,
   output logic [LEN_W-1:0]  arlen_o,
   output logic              arvalid_o,
   input  logic              arready_i,
   input  logic [DATA_W-1:0] rdata_i,
   input  logic              rvalid_i,
   input  logic              rlast_i,
   output logic              rready_o,
   // AXI-Stream output
   output logic [DATA_W-1:0] tdata_o,
   output logic              tvalid_o,
   input  logic              tready_i
);

   logic [DATA_W-1:0] fifo_wdata;
   logic              fifo_wen;
   logic              fifo_full;
   logic [DATA_W-1:0] fifo_rdata;
   logic              fifo_ren;
   logic              fifo_empty;
   logic [FIFO_AW:0]  fifo_level;

   burst_req_if #(
      .ADDR_W(ADDR_W),
      .LEN_W (LEN_W)
   ) breq_if ();

   rd_burst_planner #(
      .ADDR_W (ADDR_W),
      .DATA_W (DATA_W),
      .LEN_W  (LEN_W),
      .FIFO_AW(FIFO_AW),
      .RLEN_W (RLEN_W)
   ) u_planner (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .start_i     (start_i),
      .addr_i      (addr_i),
      .length_i    (length_i),
      .max_len_i   (max_len_i),
      .fifo_level_i(fifo_level),
      .busy_o      (busy_o),
      .breq        (breq_if.planner)
   );

   axi_rd_burst #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W),
      .LEN_W (LEN_W)
   ) u_engine (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .breq        (breq_if.engine),
      .araddr_o    (araddr_o),
      .arlen_o     (arlen_o),
      .arvalid_o   (arvalid_o),
      .arready_i   (arready_i),
      .rdata_i     (rdata_i),
      .rvalid_i    (rvalid_i),
      .rlast_i     (rlast_i),
      .rready_o    (rready_o),
      .fifo_wdata_o(fifo_wdata),
      .fifo_wen_o  (fifo_wen),
      .fifo_full_i (fifo_full)
   );

   rd_fifo #(
      .DATA_W (DATA_W),
      .FIFO_AW(FIFO_AW)
   ) u_fifo (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .wen_i  (fifo_wen),
      .wdata_i(fifo_wdata),
      .full_o (fifo_full),
      .ren_i  (fifo_ren),
      .rdata_o(fifo_rdata),
      .empty_o(fifo_empty),
      .level_o(fifo_level)
   );

   fifo2axis #(
      .DATA_W(DATA_W)
   ) u_out (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .fifo_empty_i(fifo_empty),
      .fifo_rdata_i(fifo_rdata),
      .fifo_ren_o  (fifo_ren),
      .tdata_o     (tdata_o),
      .tvalid_o    (tvalid_o),
      .tready_i    (tready_i)
   );

endmodule

//--- tests/axi_mem_model.sv
/*
 * AXI read slave model with random AR and R delays, word at byte address A is A ^ 5a5a0000
 */

`timescale 1ns/1ns

module axi_mem_model #(
   parameter int ADDR_W = axis2axi_rd_pkg::ADDR_W,
   parameter int DATA_W = axis2axi_rd_pkg::DATA_W,
   parameter int LEN_W  = axis2axi_rd_pkg::LEN_W
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic [ADDR_W-1:0] araddr_i,
   input  logic [LEN_W-1:0]  arlen_i,
   input  logic              arvalid_i,
   output logic              arready_o,
   output logic [DATA_W-1:0] rdata_o,
   output logic              rvalid_o,
   output logic              rlast_o,
   input  logic              rready_i
);

   integer seed = 32'hd7d2;

   logic              arready_q = 1'b0;
   logic              rvalid_q  = 1'b0;
   logic              rlast_q   = 1'b0;
   logic [DATA_W-1:0] rdata_q   = '0;

   // Burst being returned, address and beats still to present
   logic              active    = 1'b0;
   logic [ADDR_W-1:0] beat_addr = '0;
   logic [LEN_W:0]    left      = '0;

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
         rlast_q   <= 1'b0;
         active    <= 1'b0;
         left      <= '0;
      end else if (!active) begin
         if (arvalid_i && arready_q) begin
            arready_q <= 1'b0;
            active    <= 1'b1;
            beat_addr <= araddr_i;
            left      <= (LEN_W+1)'(arlen_i) + (LEN_W+1)'(1);
         end else begin
            arready_q <= ($random(seed) & 3) == 0;
         end
      end else if (rvalid_q && rready_i && rlast_q) begin
         rvalid_q <= 1'b0;
         rlast_q  <= 1'b0;
         active   <= 1'b0;
      end else if (!rvalid_q || rready_i) begin
         // Slot free, next beat or a gap
         if ((left != '0) && (($random(seed) & 3) != 0)) begin
            rvalid_q  <= 1'b1;
            rdata_q   <= DATA_W'(beat_addr) ^ DATA_W'(32'h5a5a_0000);
            rlast_q   <= (left == (LEN_W+1)'(1));
            beat_addr <= beat_addr + ADDR_W'(DATA_W / 8);
            left      <= left - (LEN_W+1)'(1);
         end else begin
            rvalid_q <= 1'b0;
         end
      end
   end

   assign arready_o = arready_q;
   assign rvalid_o  = rvalid_q;
   assign rlast_o   = rlast_q;
   assign rdata_o   = rdata_q;

endmodule

//--- tests/tb_axis2axi_rd.sv
/*
 * Read DMA testbench with random transfers against an AXI memory model
 * and stream, burst, busy and back-pressure checks
 */

`timescale 1ns/1ns

module tb_axis2axi_rd;

   localparam int AW      = axis2axi_rd_pkg::ADDR_W;
   localparam int DW      = axis2axi_rd_pkg::DATA_W;
   localparam int LW      = axis2axi_rd_pkg::LEN_W;
   localparam int RLW     = axis2axi_rd_pkg::RLEN_W;
   localparam int DEPTH   = 1 << axis2axi_rd_pkg::FIFO_AW;
   localparam int NXFER   = 20;
   localparam int BP_XFER = 10;
   localparam int DUP_XFER = 3;

   logic          clk;
   logic          rst_n;
   logic          start;
   logic [AW-1:0] addr;
   logic [RLW-1:0] length;
   logic [LW:0]   max_len;
   logic          busy;
   logic [AW-1:0] araddr;
   logic [LW-1:0] arlen;
   logic          arvalid;
   logic          arready;
   logic [DW-1:0] rdata;
   logic          rvalid;
   logic          rlast;
   logic          rready;
   logic [DW-1:0] tdata;
   logic          tvalid;
   logic          tready;

   integer seed = 32'hd7d2;

   logic [AW-1:0] addr_tab [NXFER];
   int            len_tab [NXFER];
   int            max_tab [NXFER];
   int            limit = 0;
   int            cycles = 0;
   logic          bp_on = 1'b0;

   // Observed stream words and AR bursts
   logic [DW-1:0] got_q [$];
   logic [AW-1:0] ar_addr_q [$];
   int            ar_len_q [$];
   int            rbeats = 0;
   logic          stall_q = 1'b0;
   logic [DW-1:0] held_q;

   int data_err  = 0;
   int burst_err = 0;
   int busy_err  = 0;
   int hold_err  = 0;
   int room_err  = 0;

   axis2axi_rd #(
      .ADDR_W (AW),
      .DATA_W (DW),
      .LEN_W  (LW),
      .FIFO_AW(axis2axi_rd_pkg::FIFO_AW),
      .RLEN_W (RLW)
   ) DUT (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .start_i  (start),
      .addr_i   (addr),
      .length_i (length),
      .max_len_i(max_len),
      .busy_o   (busy),
      .araddr_o (araddr),
      .arlen_o  (arlen),
      .arvalid_o(arvalid),
      .arready_i(arready),
      .rdata_i  (rdata),
      .rvalid_i (rvalid),
      .rlast_i  (rlast),
      .rready_o (rready),
      .tdata_o  (tdata),
      .tvalid_o (tvalid),
      .tready_i (tready)
   );

   axi_mem_model #(
      .ADDR_W(AW),
      .DATA_W(DW),
      .LEN_W (LW)
   ) mem_model (
      .clk_i    (clk),
      .rst_n_i  (rst_n),
      .araddr_i (araddr),
      .arlen_i  (arlen),
      .arvalid_i(arvalid),
      .arready_o(arready),
      .rdata_o  (rdata),
      .rvalid_o (rvalid),
      .rlast_o  (rlast),
      .rready_i (rready)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Random tready with one long stall once bp_on is set
   initial begin
      int held;
      held   = 0;
      tready = 1'b0;
      forever begin
         @(posedge clk);
         if (bp_on && (held < 300)) begin
            tready <= 1'b0;
            held = held + 1;
         end else begin
            tready <= ($random(seed) & 3) != 0;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("timeout after %0d cycles, planner in state %s", cycles,
                  DUT.u_planner.state_q.name());
         $display("Test failed");
         $finish;
      end
   end

   always @(posedge clk) begin
      if (stall_q && (!tvalid || (tdata !== held_q))) begin
         hold_err <= hold_err + 1;
         $display("mismatch at %0t: tdata %h under back-pressure, held %h", $time,
                  tdata, held_q);
      end
      stall_q <= tvalid && !tready;
      held_q  <= tdata;
      if (arvalid && arready) begin
         // Burst plus words still inside the DUT must fit FIFO and two registers
         if (int'(arlen) + 1 + rbeats - got_q.size() > DEPTH + 2) begin
            room_err <= room_err + 1;
            $display("burst of %0d beats issued at %0t without room in the FIFO",
                     int'(arlen) + 1, $time);
         end
         ar_addr_q.push_back(araddr);
         ar_len_q.push_back(int'(arlen) + 1);
      end
      if (rvalid && rready) begin
         rbeats <= rbeats + 1;
      end
      if (tvalid && tready) begin
         got_q.push_back(tdata);
      end
   end

   task automatic run_transfer(input int n);
      int            rd_base;
      int            ar_base;
      int            k;
      int            sum;
      logic [AW-1:0] exp_addr;
      logic [DW-1:0] word;
      @(negedge clk);
      if (busy) begin
         busy_err++;
         $display("busy still high before transfer %0d at %0t", n, $time);
      end
      rd_base = got_q.size();
      ar_base = ar_addr_q.size();
      @(posedge clk);
      start   <= 1'b1;
      addr    <= addr_tab[n];
      length  <= RLW'(len_tab[n]);
      max_len <= (LW+1)'(max_tab[n]);
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      if (!busy) begin
         busy_err++;
         $display("busy did not rise after start of transfer %0d at %0t", n, $time);
      end
      if (n == DUP_XFER) begin
         // Second start while busy must be ignored
         @(posedge clk);
         start  <= 1'b1;
         addr   <= addr_tab[n] ^ 32'h0000_4000;
         length <= RLW'(37);
         @(posedge clk);
         start <= 1'b0;
      end
      if (n == BP_XFER) begin
         do @(negedge clk); while (got_q.size() < rd_base + 40);
         bp_on = 1'b1;
      end
      do @(negedge clk); while (busy || (got_q.size() < rd_base + len_tab[n]));

      for (k = 0; k < len_tab[n]; k++) begin
         word = DW'(addr_tab[n] + AW'(k) * AW'(4)) ^ DW'(32'h5a5a_0000);
         if (got_q[rd_base + k] !== word) begin
            data_err++;
            $display("mismatch at %0t: transfer %0d word %0d is %h, expected %h", $time,
                     n, k, got_q[rd_base + k], word);
         end
      end
      exp_addr = addr_tab[n];
      sum = 0;
      for (k = ar_base; k < ar_addr_q.size(); k++) begin
         if (ar_len_q[k] > max_tab[n]) begin
            burst_err++;
            $display("mismatch at %0t: burst length %0d above maximum %0d", $time,
                     ar_len_q[k], max_tab[n]);
         end
         if (ar_addr_q[k] !== exp_addr) begin
            burst_err++;
            $display("mismatch at %0t: burst address %h, expected %h", $time,
                     ar_addr_q[k], exp_addr);
         end
         exp_addr = exp_addr + AW'(ar_len_q[k]) * AW'(4);
         sum += ar_len_q[k];
      end
      if (sum != len_tab[n]) begin
         burst_err++;
         $display("mismatch at %0t: transfer %0d bursts cover %0d words, expected %0d",
                  $time, n, sum, len_tab[n]);
      end
   endtask

   initial begin
      int n;
      int total;
      rst_n   = 1'b0;
      start   = 1'b0;
      addr    = '0;
      length  = '0;
      max_len = (LW+1)'(1);
      total   = 0;
      for (n = 0; n < NXFER; n++) begin
         addr_tab[n] = AW'($random(seed) & 32'h000f_fffc);
         len_tab[n]  = ($random(seed) & 32'h7fff_ffff) % 201;
         max_tab[n]  = ($random(seed) & 15) + 1;
      end
      len_tab[DUP_XFER] = 100;
      len_tab[4]        = 0;
      len_tab[BP_XFER]  = 200;
      max_tab[BP_XFER]  = 16;
      for (n = 0; n < NXFER; n++) begin
         total += len_tab[n];
      end
      limit = total * 40 + 2000;

      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      for (n = 0; n < NXFER; n++) begin
         run_transfer(n);
      end
      repeat (50) @(posedge clk);
      if (got_q.size() != total) begin
         data_err++;
         $display("mismatch at %0t: stream delivered %0d words in total, expected %0d",
                  $time, got_q.size(), total);
      end

      $display("errors: data %0d, burst %0d, busy %0d, hold %0d, room %0d",
               data_err, burst_err, busy_err, hold_err, room_err);
      if ((data_err + burst_err + busy_err + hold_err + room_err) == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- list.f
rtl/axis2axi_rd_pkg.sv
rtl/burst_req_if.sv
rtl/rd_burst_planner.sv
rtl/axi_rd_burst.sv
rtl/rd_fifo.sv
rtl/fifo2axis.sv
rtl/axis2axi_rd.sv
tests/axi_mem_model.sv
tests/tb_axis2axi_rd.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the read DMA testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal -j 0 -f list.f \
   --top-module tb_axis2axi_rd -o tb_sim \
   && ./obj_dir/tb_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "^Test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
